// ==== list.f ====
+incdir+source
+incdir+sim
source/player_pkg.sv
source/keyRegAxi.sv
source/frameTick.sv
source/walkCounter.sv
source/playerSprite.sv
source/playerTop.sv
sim/playerTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the player testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f list.f --top-module playerTb -o playerSim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/playerSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^SIMULATION PASSED$" "$LOG"; then
    exit 0
else
    echo "Pass message not found in $LOG"
    exit 1
fi

// ==== sim/playerTbTasks.svh ====
// AXI4-Lite master tasks, typed compare tasks and probe helpers for the player testbench
`ifndef PLAYER_TB_TASKS_SVH
`define PLAYER_TB_TASKS_SVH

task automatic reportMismatch(input string msg);
    errorCount++;
    testErrors++;
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
endtask

task automatic reportFailure(input string msg);
    errorCount++;
    testErrors++;
    $display("ERROR at %0t ns: %s", $time, msg);
endtask

task automatic checkFacing(input facingT got, input facingT exp, input string what);
    checkCount++;
    if (got !== exp)
        reportMismatch($sformatf("%s is %s, expected %s", what, got.name(), exp.name()));
endtask

task automatic checkCoord(input logic [8:0] got, input logic [8:0] exp, input string what);
    checkCount++;
    if (got !== exp)
        reportMismatch($sformatf("%s is %0d, expected %0d", what, got, exp));
endtask

task automatic checkAddress(input logic [12:0] got, input logic [12:0] exp, input string what);
    checkCount++;
    if (got !== exp)
        reportMismatch($sformatf("%s is %0d, expected %0d", what, got, exp));
endtask

task automatic checkHit(input logic got, input logic exp, input string what);
    checkCount++;
    if (got !== exp)
        reportMismatch($sformatf("%s is %0b, expected %0b", what, got, exp));
endtask

task automatic checkData(input logic [31:0] got, input logic [31:0] exp, input string what);
    checkCount++;
    if (got !== exp)
        reportMismatch($sformatf("%s is 0x%08h, expected 0x%08h", what, got, exp));
endtask

// bReady stays low for holdoff cycles after bValid rises
task automatic writeReg(input logic [3:0] addr, input logic [31:0] data,
                        input logic [3:0] strb, input int holdoff);
    int waitCnt;
    @(negedge Clk);
    awAddr  = addr;
    wData   = data;
    wStrb   = strb;
    awValid = 1'b1;
    wValid  = 1'b1;
    waitCnt = 0;
    while (!(awReady && wReady) && waitCnt < HANDSHAKE_LIMIT)
    begin
        @(negedge Clk);
        waitCnt++;
    end
    if (!(awReady && wReady))
        reportFailure("awReady and wReady never rose for a write");
    @(negedge Clk);                     // Handshake edge has passed
    awValid = 1'b0;
    wValid  = 1'b0;
    case (addr)
        `REG_KEY:    if (strb[0]) modelKey = data[7:0];
        `REG_ATTACK: modelAttack = data[0];
        default: ;
    endcase
    waitCnt = 0;
    while (!bValid && waitCnt < HANDSHAKE_LIMIT)
    begin
        @(negedge Clk);
        waitCnt++;
    end
    if (!bValid)
        reportFailure("bValid never rose after a write");
    if (bResp !== 2'b00)
        reportFailure("write response was not OKAY");
    repeat (holdoff)
    begin
        @(negedge Clk);
        if (!bValid)
            reportFailure("bValid dropped before bReady");
    end
    bReady = 1'b1;
    @(negedge Clk);
    bReady = 1'b0;
endtask

// rReady stays low for holdoff cycles; rData must hold its first value
task automatic readReg(input logic [3:0] addr, input int holdoff, output logic [31:0] data);
    int waitCnt;
    @(negedge Clk);
    arAddr  = addr;
    arValid = 1'b1;
    waitCnt = 0;
    while (!arReady && waitCnt < HANDSHAKE_LIMIT)
    begin
        @(negedge Clk);
        waitCnt++;
    end
    if (!arReady)
        reportFailure("arReady never rose for a read");
    @(negedge Clk);
    arValid = 1'b0;
    waitCnt = 0;
    while (!rValid && waitCnt < HANDSHAKE_LIMIT)
    begin
        @(negedge Clk);
        waitCnt++;
    end
    if (!rValid)
        reportFailure("rValid never rose after a read");
    if (rResp !== 2'b00)
        reportFailure("read response was not OKAY");
    data = rData;
    arAddr = ~addr;                     // Address may change once accepted
    repeat (holdoff)
    begin
        @(negedge Clk);
        if (!rValid)
            reportFailure("rValid dropped before rReady");
        checkData(rData, data, "held rData");
    end
    rReady = 1'b1;
    @(negedge Clk);
    rReady = 1'b0;
endtask

task automatic waitFrames(input int n);
    int target;
    target = modelFrames + n;
    while (modelFrames < target)
        @(negedge Clk);
endtask

// Position, facing and frame count through the register port
task automatic checkPosition(input int holdoff);
    logic [31:0] rd;
    readReg(`REG_POS, holdoff, rd);
    checkCoord(rd[8:0], 9'(modelX), "x position");
    checkCoord(rd[24:16], 9'(modelY), "y position");
    checkFacing(facingT'(rd[29:28]), modelFacing, "facing");
    readReg(`REG_FRAME, holdoff, rd);
    checkData(rd, {16'd0, 16'(modelFrames)}, "frame count");
endtask

task automatic holdKey(input logic [7:0] key, input int frames);
    writeReg(`REG_KEY, {24'd0, key}, 4'h1, 0);
    waitFrames(frames);
    checkPosition(0);
endtask

task automatic probePixel(input logic [8:0] px, input logic [8:0] py);
    int expAddr;
    @(negedge Clk);
    pixelX = px;
    pixelY = py;
    #(CLK_PERIOD / 4);                  // Settle before the next rising edge
    expAddr = expectAddr(px, py);
    checkHit(isObj, expAddr >= 0, $sformatf("isObj at (%0d,%0d)", px, py));
    checkAddress(objAddress, (expAddr >= 0) ? 13'(expAddr) : 13'd0, "objAddress");
endtask

// Mostly near the sprite box, sometimes anywhere
task automatic probeRandom();
    logic [8:0] px;
    logic [8:0] py;
    if ($urandom % 4 == 0)
    begin
        px = 9'($urandom);
        py = 9'($urandom);
    end
    else
    begin
        px = 9'(modelX - 3 + int'($urandom % 24));
        py = 9'(modelY - 3 + int'($urandom % 26));
    end
    probePixel(px, py);
endtask

task automatic finishTest(input string name);
    if (testErrors == 0)
        $display("Test %s: ok", name);
    else
        $display("Test %s: %0d errors", name, testErrors);
    testErrors = 0;
endtask

`endif

// ==== sim/playerTb.sv ====
// Player testbench: clock, reset, DUT, frame reference model, test sequence and timeout
`timescale 1ns/1ns
`include "player_cfg.svh"

module playerTb import player_pkg::*;
();

    localparam int CLK_PERIOD      = 20;
    localparam int HANDSHAKE_LIMIT = 16;
    localparam int TEST_FRAMES     = 520;   // Longest case over all tests, bounds hold dominates
    localparam int CYCLE_LIMIT     = TEST_FRAMES * `FRAME_CYCLES + 2000;
    localparam int SPR_W   = int'(`SPRITE_W);
    localparam int SPR_H   = int'(`SPRITE_H);
    localparam int STEP_PX = int'(`STEP);

    logic        Clk;
    logic        rstN;
    logic [3:0]  awAddr;
    logic        awValid;
    logic        awReady;
    logic [31:0] wData;
    logic [3:0]  wStrb;
    logic        wValid;
    logic        wReady;
    logic [1:0]  bResp;
    logic        bValid;
    logic        bReady;
    logic [3:0]  arAddr;
    logic        arValid;
    logic        arReady;
    logic [31:0] rData;
    logic [1:0]  rResp;
    logic        rValid;
    logic        rReady;
    logic [8:0]  pixelX;
    logic [8:0]  pixelY;
    logic        isObj;
    logic [12:0] objAddress;

    // Reference model
    int         modelX;
    int         modelY;
    int         modelStep;
    int         modelFrames;
    int         cycleInFrame;
    int         cycleCount;
    facingT     modelFacing;
    logic [7:0] modelKey;
    logic       modelAttack;

    int errorCount;
    int checkCount;
    int testErrors;

    playerTop i_dut (.*);

    initial
    begin
        Clk = 1'b0;
        forever #(CLK_PERIOD / 2) Clk = ~Clk;
    end

    // One game frame of the movement rules
    function automatic void applyFrame();
        logic moved;
        moved = 1'b0;
        case (modelKey)
            `KEY_UP:
            begin
                modelFacing = faceUp;
                moved = (modelY > int'(`Y_MIN));
                if (moved) modelY -= STEP_PX;
            end
            `KEY_DOWN:
            begin
                modelFacing = faceDown;
                moved = (modelY + SPR_H < int'(`Y_MAX));
                if (moved) modelY += STEP_PX;
            end
            `KEY_LEFT:
            begin
                modelFacing = faceLeft;
                moved = (modelX > int'(`X_MIN));
                if (moved) modelX -= STEP_PX;
            end
            `KEY_RIGHT:
            begin
                modelFacing = faceRight;
                moved = (modelX + SPR_W < int'(`X_MAX));
                if (moved) modelX += STEP_PX;
            end
            default: ;
        endcase
        modelStep = moved ? (modelStep + 1) % 4 : 0;
        modelFrames++;
    endfunction

    // Sprite sheet address, or -1 when the pixel is off the player
    function automatic int expectAddr(logic [8:0] px, logic [8:0] py);
        int x;
        int y;
        int idx;
        x = int'(px);
        y = int'(py);
        if (x < modelX || x >= modelX + SPR_W || y < modelY || y >= modelY + SPR_H)
            return -1;
        if (modelAttack)
            idx = 4 * int'(modelFacing) + 3;
        else if (modelStep % 2 == 0)
            idx = 4 * int'(modelFacing);
        else
            idx = 4 * int'(modelFacing) + 1 + modelStep / 2;
        return (x - modelX) + (y - modelY) * SPR_W + SPR_W * SPR_H * idx;
    endfunction

    function automatic logic [7:0] pickKey();
        case ($urandom % 5)
            0:       return `KEY_UP;
            1:       return `KEY_DOWN;
            2:       return `KEY_LEFT;
            3:       return `KEY_RIGHT;
            default: return 8'h2C;      // Space bar, no move
        endcase
    endfunction

    // Frame boundaries counted from reset release, plus the run limit
    always @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
        begin
            modelX       = int'(`START_X);
            modelY       = int'(`START_Y);
            modelFacing  = faceDown;
            modelStep    = 0;
            modelFrames  = 0;
            cycleInFrame = 0;
            cycleCount   = 0;
        end
        else
        begin
            cycleCount++;
            if (cycleInFrame == `FRAME_CYCLES - 1)
            begin
                cycleInFrame = 0;
                applyFrame();
            end
            else
                cycleInFrame++;
            if (cycleCount >= CYCLE_LIMIT)
            begin
                $display("Timeout: tests still running after %0d cycles", cycleCount);
                $display("SIMULATION FAILED");
                $finish;
            end
        end
    end

    `include "playerTbTasks.svh"

    initial
    begin
        logic [31:0] rd;
        logic [31:0] wr;
        logic [7:0]  key;
        int          hold;
        int          seedValue;
        seedValue   = $urandom(62);
        rstN        = 1'b0;
        awAddr      = 4'h0;
        awValid     = 1'b0;
        wData       = 32'd0;
        wStrb       = 4'h0;
        wValid      = 1'b0;
        bReady      = 1'b0;
        arAddr      = 4'h0;
        arValid     = 1'b0;
        rReady      = 1'b0;
        pixelX      = 9'd0;
        pixelY      = 9'd0;
        modelKey    = 8'd0;
        modelAttack = 1'b0;
        errorCount  = 0;
        checkCount  = 0;
        testErrors  = 0;
        repeat (3) @(posedge Clk);
        @(negedge Clk);
        rstN = 1'b1;

        repeat (6)
        begin
            key = 8'($urandom);
            writeReg(`REG_KEY, {24'($urandom), key}, 4'hF, 0);
            readReg(`REG_KEY, 0, rd);
            checkData(rd, {24'd0, key}, "REG_KEY");
            wr = $urandom;
            writeReg(`REG_ATTACK, wr, 4'hF, 0);
            readReg(`REG_ATTACK, 0, rd);
            checkData(rd, {31'd0, wr[0]}, "REG_ATTACK");
        end
        writeReg(`REG_KEY, {24'd0, ~key}, 4'b1110, 0);  // Byte lane 0 off
        writeReg(4'h2, {24'hFF_FFFF, ~key}, 4'hF, 0);
        readReg(`REG_KEY, 0, rd);
        checkData(rd, {24'd0, key}, "REG_KEY after ignored writes");
        readReg(4'h2, 0, rd);
        checkData(rd, 32'd0, "unmapped offset");
        writeReg(`REG_KEY, 32'd0, 4'hF, 0);
        writeReg(`REG_ATTACK, 32'd0, 4'hF, 0);
        waitFrames(1);
        checkPosition(0);
        finishTest("registers");

        repeat (10)
        begin
            writeReg(`REG_KEY, {24'd0, pickKey()}, 4'h1, 0);
            hold = 1 + int'($urandom % 5);
            repeat (hold)
            begin
                waitFrames(1);
                checkPosition(0);
            end
        end
        finishTest("movement");

        // Long holds reach every edge, then a blocked key still turns the player
        holdKey(`KEY_LEFT, 110);
        holdKey(`KEY_UP, 60);
        holdKey(`KEY_RIGHT, 110);
        holdKey(`KEY_DOWN, 60);
        holdKey(`KEY_RIGHT, 2);
        finishTest("bounds");

        repeat (12)
        begin
            writeReg(`REG_KEY, {24'd0, pickKey()}, 4'h1, 0);
            hold = 1 + int'($urandom % 3);
            repeat (hold)
            begin
                waitFrames(1);
                repeat (6) probeRandom();
            end
        end
        finishTest("walk animation");

        writeReg(`REG_ATTACK, 32'd1, 4'hF, 0);
        repeat (8)
        begin
            writeReg(`REG_KEY, {24'd0, pickKey()}, 4'h1, 0);
            waitFrames(1);
            probePixel(9'(modelX), 9'(modelY));
            repeat (4) probeRandom();
        end
        writeReg(`REG_ATTACK, 32'd0, 4'hF, 0);
        finishTest("attack");

        repeat (8)
        begin
            key = pickKey();
            writeReg(`REG_KEY, {24'd0, key}, 4'h1, 1 + int'($urandom % 10));
            waitFrames(1);
            checkPosition(1 + int'($urandom % 10));
            readReg(`REG_KEY, 1 + int'($urandom % 10), rd);
            checkData(rd, {24'd0, key}, "REG_KEY under back-pressure");
        end
        finishTest("back-pressure");

        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== source/frameTick.sv ====
// Game-frame tick generator with a wrapping frame counter
`timescale 1ns/1ns
`include "player_cfg.svh"

module frameTick
(
    input  logic        Clk,
    input  logic        rstN,
    output logic        frameStart,
    output logic [15:0] frameCount
);

    localparam int CNT_W = $clog2(`FRAME_CYCLES);

    logic [CNT_W-1:0] cycleCnt;

    // Pulse on the last cycle of each frame period
    assign frameStart = (cycleCnt == CNT_W'(`FRAME_CYCLES - 1));

    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
        begin
            cycleCnt   <= '0;
            frameCount <= 16'd0;
        end
        else
        begin
            if (frameStart)
            begin
                cycleCnt   <= '0;
                frameCount <= frameCount + 16'd1;   // Wraps at 16 bits
            end
            else
                cycleCnt <= cycleCnt + CNT_W'(1);
        end
    end

endmodule

// ==== source/keyRegAxi.sv ====
// AXI4-Lite register slave for keycode and attack flag, with position and frame count readback
`timescale 1ns/1ns
`include "player_cfg.svh"

module keyRegAxi import player_pkg::*;
(
    input  logic        Clk,
    input  logic        rstN,
    input  logic [3:0]  awAddr,
    input  logic        awValid,
    output logic        awReady,
    input  logic [31:0] wData,
    input  logic [3:0]  wStrb,
    input  logic        wValid,
    output logic        wReady,
    output logic [1:0]  bResp,
    output logic        bValid,
    input  logic        bReady,
    input  logic [3:0]  arAddr,
    input  logic        arValid,
    output logic        arReady,
    output logic [31:0] rData,
    output logic [1:0]  rResp,
    output logic        rValid,
    input  logic        rReady,
    input  logic [8:0]  xPos,
    input  logic [8:0]  yPos,
    input  facingT      facing,
    input  logic [15:0] frameCount,
    output logic [7:0]  keycode,
    output logic        attackOn
);

    axiWriteStateT wrState;
    axiReadStateT  rdState;
    logic [31:0]   readMux;

    assign awReady = (wrState == wrAccept);
    assign wReady  = (wrState == wrAccept);
    assign bValid  = (wrState == wrResp);
    assign bResp   = 2'b00;                 // Always OKAY

    assign arReady = (rdState == rdAccept);
    assign rValid  = (rdState == rdResp);
    assign rResp   = 2'b00;

    // Write sequencing and register update
    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
        begin
            wrState  <= wrIdle;
            keycode  <= 8'd0;
            attackOn <= 1'b0;
        end
        else
        begin
            case (wrState)
                wrIdle:
                    if (awValid && wValid)
                        wrState <= wrAccept;
                wrAccept:
                begin
                    wrState <= wrResp;      // Handshake completes on this edge
                    case (awAddr)
                        `REG_KEY:
                            if (wStrb[0])
                                keycode <= wData[7:0];
                        `REG_ATTACK: attackOn <= wData[0];
                        default: ;          // Read-only or unmapped
                    endcase
                end
                wrResp:
                    if (bReady)
                        wrState <= wrIdle;
                default: wrState <= wrIdle;
            endcase
        end
    end

    // Readback mux
    always_comb
    begin
        case (arAddr)
            `REG_KEY:    readMux = {24'd0, keycode};
            `REG_ATTACK: readMux = {31'd0, attackOn};
            `REG_POS:    readMux = {2'd0, facing, 3'd0, yPos, 7'd0, xPos};
            `REG_FRAME:  readMux = {16'd0, frameCount};
            default:     readMux = 32'd0;
        endcase
    end

    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
            rdState <= rdIdle;
        else
        begin
            case (rdState)
                rdIdle:   if (arValid) rdState <= rdAccept;
                rdAccept: rdState <= rdResp;
                rdResp:   if (rReady) rdState <= rdIdle;
                default:  rdState <= rdIdle;
            endcase
        end
    end

    // Read data is captured once and held through back-pressure
    always_ff @(posedge Clk)
    begin
        if (rdState == rdAccept)
            rData <= readMux;
    end

endmodule

// ==== source/playerSprite.sv ====
// Player motion with edge clamping, facing update, walk counter and sprite pixel addressing
`timescale 1ns/1ns
`include "player_cfg.svh"

module playerSprite import player_pkg::*;
(
    input  logic        Clk,
    input  logic        rstN,
    input  logic        frameStart,
    input  logic [7:0]  keycode,
    input  logic        attackOn,
    input  logic [8:0]  pixelX,
    input  logic [8:0]  pixelY,
    output logic        isObj,
    output logic [12:0] objAddress,
    output logic [8:0]  xPos,
    output logic [8:0]  yPos,
    output facingT      facing
);

    localparam logic [12:0] FRAME_SIZE = 13'(`SPRITE_W) * 13'(`SPRITE_H);

    moveCmdT    moveCmd;
    logic [8:0] xNext;
    logic [8:0] yNext;
    facingT     facingNext;
    logic       moving;
    logic [1:0] stepCount;
    logic [9:0] xEnd;
    logic [9:0] yEnd;
    logic [8:0] dx;
    logic [8:0] dy;
    logic [3:0] frameIdx;

    // Far edges of the sprite box, one bit wider to avoid overflow
    assign xEnd = {1'b0, xPos} + 10'(`SPRITE_W);
    assign yEnd = {1'b0, yPos} + 10'(`SPRITE_H);

    always_comb
    begin
        case (keycode)
            `KEY_UP:    moveCmd = moveUp;
            `KEY_DOWN:  moveCmd = moveDown;
            `KEY_LEFT:  moveCmd = moveLeft;
            `KEY_RIGHT: moveCmd = moveRight;
            default:    moveCmd = moveNone;
        endcase
    end

    // Facing follows the key even when the move is blocked
    always_comb
    begin
        xNext      = xPos;
        yNext      = yPos;
        facingNext = facing;
        moving     = 1'b0;
        case (moveCmd)
            moveUp:
            begin
                facingNext = faceUp;
                if (yPos > `Y_MIN)
                begin
                    yNext  = yPos - `STEP;
                    moving = 1'b1;
                end
            end
            moveDown:
            begin
                facingNext = faceDown;
                if (yEnd < 10'(`Y_MAX))
                begin
                    yNext  = yPos + `STEP;
                    moving = 1'b1;
                end
            end
            moveLeft:
            begin
                facingNext = faceLeft;
                if (xPos > `X_MIN)
                begin
                    xNext  = xPos - `STEP;
                    moving = 1'b1;
                end
            end
            moveRight:
            begin
                facingNext = faceRight;
                if (xEnd < 10'(`X_MAX))
                begin
                    xNext  = xPos + `STEP;
                    moving = 1'b1;
                end
            end
            default: ;  // No key, stand still
        endcase
    end

    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
        begin
            xPos   <= `START_X;
            yPos   <= `START_Y;
            facing <= faceDown;
        end
        else if (frameStart)
        begin
            xPos   <= xNext;
            yPos   <= yNext;
            facing <= facingNext;
        end
    end

    walkCounter i_walkCounter
    (
        .Clk        (Clk),
        .rstN       (rstN),
        .frameStart (frameStart),
        .moving     (moving),
        .stepCount  (stepCount)
    );

    // Attack frame overrides the walk cycle
    always_comb
    begin
        if (attackOn)
            frameIdx = {facing, 2'd3};
        else if (!stepCount[0])
            frameIdx = {facing, 2'd0};
        else
            frameIdx = {facing, 1'b0, stepCount[1]} + 4'd1;    // Walk frame 1 or 2
    end

    assign dx = pixelX - xPos;
    assign dy = pixelY - yPos;

    assign isObj = ({1'b0, pixelX} >= {1'b0, xPos}) && ({1'b0, pixelX} < xEnd) &&
                   ({1'b0, pixelY} >= {1'b0, yPos}) && ({1'b0, pixelY} < yEnd);

    // Offset inside the frame plus the frame base in the sheet
    assign objAddress = isObj ? (13'(dx) + 13'(dy) * 13'(`SPRITE_W) + FRAME_SIZE * 13'(frameIdx))
                              : 13'd0;

endmodule

// ==== source/playerTop.sv ====
// Top level joining the AXI4-Lite register port, frame tick generator and player sprite
`timescale 1ns/1ns

module playerTop import player_pkg::*;
(
    input  logic        Clk,
    input  logic        rstN,
    input  logic [3:0]  awAddr,
    input  logic        awValid,
    output logic        awReady,
    input  logic [31:0] wData,
    input  logic [3:0]  wStrb,
    input  logic        wValid,
    output logic        wReady,
    output logic [1:0]  bResp,
    output logic        bValid,
    input  logic        bReady,
    input  logic [3:0]  arAddr,
    input  logic        arValid,
    output logic        arReady,
    output logic [31:0] rData,
    output logic [1:0]  rResp,
    output logic        rValid,
    input  logic        rReady,
    input  logic [8:0]  pixelX,
    input  logic [8:0]  pixelY,
    output logic        isObj,
    output logic [12:0] objAddress
);

    logic        frameStart;
    logic [15:0] frameCount;
    logic [7:0]  keycode;
    logic        attackOn;
    logic [8:0]  xPos;
    logic [8:0]  yPos;
    facingT      facing;

    keyRegAxi i_regs
    (
        .Clk        (Clk),
        .rstN       (rstN),
        .awAddr     (awAddr),
        .awValid    (awValid),
        .awReady    (awReady),
        .wData      (wData),
        .wStrb      (wStrb),
        .wValid     (wValid),
        .wReady     (wReady),
        .bResp      (bResp),
        .bValid     (bValid),
        .bReady     (bReady),
        .arAddr     (arAddr),
        .arValid    (arValid),
        .arReady    (arReady),
        .rData      (rData),
        .rResp      (rResp),
        .rValid     (rValid),
        .rReady     (rReady),
        .xPos       (xPos),
        .yPos       (yPos),
        .facing     (facing),
        .frameCount (frameCount),
        .keycode    (keycode),
        .attackOn   (attackOn)
    );

    frameTick i_tick
    (
        .Clk        (Clk),
        .rstN       (rstN),
        .frameStart (frameStart),
        .frameCount (frameCount)
    );

    // Motion and per-pixel lookup
    playerSprite i_player
    (
        .Clk        (Clk),
        .rstN       (rstN),
        .frameStart (frameStart),
        .keycode    (keycode),
        .attackOn   (attackOn),
        .pixelX     (pixelX),
        .pixelY     (pixelY),
        .isObj      (isObj),
        .objAddress (objAddress),
        .xPos       (xPos),
        .yPos       (yPos),
        .facing     (facing)
    );

endmodule

// ==== source/player_cfg.svh ====
// Keycodes, playfield bounds, sprite geometry, step, start position, frame period, register map
`ifndef PLAYER_CFG_SVH
`define PLAYER_CFG_SVH

// Arrow keycodes from the keyboard
`define KEY_UP          8'd82
`define KEY_DOWN        8'd81
`define KEY_LEFT        8'd80
`define KEY_RIGHT       8'd79

// Playfield bounds in 9-bit pixel coordinates
`define X_MIN           9'd1
`define X_MAX           9'd319
`define Y_MIN           9'd52
`define Y_MAX           9'd205

`define SPRITE_W        9'd18     // Sprite width in pixels
`define SPRITE_H        9'd20     // Sprite height in pixels
`define STEP            9'd3      // Pixels per frame

// Reset position, centred on a 320x240 screen
`define START_X         (9'd160 - (`SPRITE_W >> 1))
`define START_Y         (9'd120 - (`SPRITE_H >> 1))

`define FRAME_CYCLES    64        // Clock cycles per game frame

// Register byte offsets
`define REG_KEY         4'h0
`define REG_ATTACK      4'h4
`define REG_POS         4'h8
`define REG_FRAME       4'hC

`endif

// ==== source/player_pkg.sv ====
// Shared types: facing direction, move command and the AXI write/read state enums
package player_pkg;

    // Each direction selects a group of four sprite frames
    typedef enum logic [1:0]
    {
        faceDown  = 2'd0,
        faceLeft  = 2'd1,
        faceUp    = 2'd2,
        faceRight = 2'd3
    } facingT;

    // Decoded from the keycode
    typedef enum logic [2:0]
    {
        moveNone,
        moveUp,
        moveDown,
        moveLeft,
        moveRight
    } moveCmdT;

    typedef enum logic [1:0]
    {
        wrIdle,     // Waiting for address and data
        wrAccept,   // awReady and wReady high
        wrResp      // bValid held until bReady
    } axiWriteStateT;

    typedef enum logic [1:0]
    {
        rdIdle,     // Waiting for arValid
        rdAccept,   // arReady high
        rdResp      // rValid held until rReady
    } axiReadStateT;

endpackage

// ==== source/walkCounter.sv ====
// Two-bit walk step counter driving the walking animation frames
`timescale 1ns/1ns

module walkCounter
(
    input  logic       Clk,
    input  logic       rstN,
    input  logic       frameStart,
    input  logic       moving,
    output logic [1:0] stepCount
);

    // Advances once per moving frame, back to standing when still
    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
            stepCount <= 2'd0;
        else if (frameStart)
        begin
            if (moving)
                stepCount <= stepCount + 2'd1;  // Modulo 4
            else
                stepCount <= 2'd0;
        end
    end

endmodule
